//--- fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_W      = 32;
    localparam int INST_W      = 32;
    localparam int QUEUE_DEPTH = 16;
    localparam int QIDX_W      = $clog2(QUEUE_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [QIDX_W-1:0] qidx_t;

    localparam addr_t RESET_PC   = '0;
    localparam addr_t INST_BYTES = 4;

    // jump encoding keeps the opcode in the low bits and the target page in the high bits
    localparam int              OPCODE_W    = 7;
    localparam logic [OPCODE_W-1:0] JUMP_OPCODE = 7'b1101111;
    localparam int              TARGET_LSB  = 12;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        inst_t inst;
    } fetch_resp_t;

    function automatic logic is_jump(inst_t inst);
        return inst[OPCODE_W-1:0] == JUMP_OPCODE;
    endfunction

    // upper field of the word with the low bits cleared
    function automatic addr_t jump_target(inst_t inst);
        return {inst[INST_W-1:TARGET_LSB], {TARGET_LSB{1'b0}}};
    endfunction

endpackage

//--- predict_pkg.sv
package predict_pkg;

    localparam int PRED_ENTRIES = 32;
    localparam int PRED_IDX_W   = $clog2(PRED_ENTRIES);
    localparam int PRED_IDX_LSB = 2;

    typedef logic [PRED_IDX_W-1:0] pred_idx_t;

    typedef enum logic [1:0] {
        strong_not   = 2'd0,
        weak_not     = 2'd1,
        weak_taken   = 2'd2,
        strong_taken = 2'd3
    } pred_cnt_e;

    typedef struct packed {
        logic              valid;
        fetch_pkg::addr_t  pc;
        logic              taken;
        fetch_pkg::addr_t  target;
    } pred_update_t;

    // word address bits select the table entry
    function automatic pred_idx_t pred_index(fetch_pkg::addr_t pc);
        return pc[PRED_IDX_LSB +: PRED_IDX_W];
    endfunction

endpackage

//--- branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import fetch_pkg::*;
    import predict_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  addr_t        pc,
    output addr_t        next_pc,
    input  pred_update_t update
);

    pred_cnt_e cnt_q [PRED_ENTRIES];
    addr_t     tgt_q [PRED_ENTRIES];

    pred_idx_t rd_idx;
    pred_idx_t wr_idx;
    pred_cnt_e rd_cnt;
    logic      rd_taken;

    // saturating step toward the resolved direction
    function automatic pred_cnt_e cnt_step(pred_cnt_e cnt, logic taken);
        pred_cnt_e nxt;
        nxt = cnt;
        case (cnt)
            strong_not:   nxt = taken ? weak_not : strong_not;
            weak_not:     nxt = taken ? weak_taken : strong_not;
            weak_taken:   nxt = taken ? strong_taken : weak_not;
            strong_taken: nxt = taken ? strong_taken : weak_taken;
            default:      nxt = weak_not;
        endcase
        return nxt;
    endfunction

    assign rd_idx   = pred_index(pc);
    assign wr_idx   = pred_index(update.pc);
    assign rd_cnt   = cnt_q[rd_idx];
    assign rd_taken = (rd_cnt == weak_taken) || (rd_cnt == strong_taken);

    // stored target only when the counter says taken
    assign next_pc = rd_taken ? tgt_q[rd_idx] : pc + INST_BYTES;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PRED_ENTRIES; i++) begin
                cnt_q[i] <= weak_not;
            end
        end else if (update.valid) begin
            cnt_q[wr_idx] <= cnt_step(cnt_q[wr_idx], update.taken);
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            tgt_q[wr_idx] <= update.target;
        end
    end

endmodule

//--- inst_queue.sv
`timescale 1ns/1ps

module inst_queue
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  addr_t       next_pc,
    output addr_t       pc,
    output fetch_req_t  mem_req,
    input  logic        mem_ready,
    input  fetch_resp_t mem_resp,
    output fetch_resp_t head,
    input  logic        head_ready,
    input  fetch_req_t  redirect
);

    addr_t pc_q;
    logic  pending_q;
    addr_t pend_addr_q;
    qidx_t head_q;
    qidx_t tail_q;

    addr_t addr_mem [QUEUE_DEPTH];
    inst_t inst_mem [QUEUE_DEPTH];

    qidx_t used;
    logic  empty;
    logic  near_full;
    logic  resp_hit;
    logic  req_fire;
    logic  head_pop;

    assign used      = tail_q - head_q;
    assign empty     = (head_q == tail_q);
    // keep one spare slot beyond the read in flight
    assign near_full = (used >= qidx_t'(QUEUE_DEPTH - 2));

    // responses for an older, dropped read carry a different address
    assign resp_hit = pending_q && mem_resp.valid && (mem_resp.addr == pend_addr_q);

    assign pc = pc_q;

    // one read at a time until the last one has returned
    assign mem_req.valid = !pending_q && !near_full;
    assign mem_req.addr  = pc_q;
    assign req_fire      = mem_req.valid && mem_ready;

    // bypass the buffer when it holds nothing
    assign head.valid = !empty || resp_hit;
    assign head.addr  = empty ? mem_resp.addr : addr_mem[head_q];
    assign head.inst  = empty ? mem_resp.inst : inst_mem[head_q];
    assign head_pop   = head.valid && head_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= RESET_PC;
            pending_q <= 1'b0;
            head_q    <= '0;
            tail_q    <= '0;
        end else if (redirect.valid) begin
            // flush, drop the read in flight and restart fetch
            head_q    <= tail_q;
            pc_q      <= redirect.addr;
            pending_q <= 1'b0;
        end else begin
            if (resp_hit) begin
                pending_q <= 1'b0;
                tail_q    <= tail_q + 1'b1;
            end
            if (req_fire) begin
                pending_q <= 1'b1;
                pc_q      <= next_pc;
            end
            if (head_pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pend_addr_q <= pc_q;
        end
    end

    // a bypassed word is written too and head moves past it when taken
    always_ff @(posedge clk) begin
        if (resp_hit) begin
            addr_mem[tail_q] <= mem_resp.addr;
            inst_mem[tail_q] <= mem_resp.inst;
        end
    end

endmodule

//--- branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve
    import fetch_pkg::*;
    import predict_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fetch_resp_t  head,
    output logic         head_ready,
    output fetch_req_t   redirect,
    output pred_update_t update,
    output logic         out_valid,
    output addr_t        out_pc,
    output inst_t        out_inst,
    input  logic         out_ready
);

    addr_t        expect_q;
    pred_update_t update_q;

    logic  on_path;
    logic  out_free;
    logic  accept;
    logic  head_jump;
    addr_t head_next;

    assign on_path   = (head.addr == expect_q);
    assign out_free  = !out_valid || out_ready;
    assign head_ready = out_free && on_path;
    assign accept    = head.valid && head_ready;

    assign head_jump = is_jump(head.inst);
    assign head_next = head_jump ? jump_target(head.inst) : head.addr + INST_BYTES;

    // a wrong head restarts fetch at the architectural next address
    assign redirect.valid = head.valid && !on_path;
    assign redirect.addr  = expect_q;

    assign update = update_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            expect_q       <= RESET_PC;
            out_valid      <= 1'b0;
            update_q.valid <= 1'b0;
        end else begin
            update_q.valid <= accept;
            if (accept) begin
                expect_q  <= head_next;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // output word and training data
    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc          <= head.addr;
            out_inst        <= head.inst;
            update_q.pc     <= head.addr;
            update_q.taken  <= head_jump;
            update_q.target <= head_next;
        end
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
    import predict_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output fetch_req_t  mem_req,
    input  logic        mem_ready,
    input  fetch_resp_t mem_resp,
    output logic        out_valid,
    output addr_t       out_pc,
    output inst_t       out_inst,
    input  logic        out_ready
);

    addr_t        pc;
    addr_t        next_pc;
    fetch_resp_t  head;
    logic         head_ready;
    fetch_req_t   redirect;
    pred_update_t update;

    branch_predictor i_branch_predictor (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .next_pc (next_pc),
        .update  (update)
    );

    inst_queue i_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .next_pc    (next_pc),
        .pc         (pc),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_resp   (mem_resp),
        .head       (head),
        .head_ready (head_ready),
        .redirect   (redirect)
    );

    branch_resolve i_branch_resolve (
        .clk        (clk),
        .rst        (rst),
        .head       (head),
        .head_ready (head_ready),
        .redirect   (redirect),
        .update     (update),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_ready  (out_ready)
    );

endmodule

//--- fetch_assert.sv
`timescale 1ns/1ps

module fetch_assert
    import fetch_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input fetch_req_t mem_req,
    input logic       mem_ready,
    input logic       out_valid,
    input addr_t      out_pc,
    input inst_t      out_inst,
    input logic       out_ready,
    input fetch_req_t redirect
);

    int fail_count = 0;

    // output register holds while downstream stalls
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_valid) && $stable(out_pc) && $stable(out_inst))
    else begin
        fail_count++;
        $error("out_* changed while out_ready was low");
    end

    // a redirect reloads pc and so may move the request
    req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_ready && !redirect.valid |=> $stable(mem_req))
    else begin
        fail_count++;
        $error("mem_req changed while mem_ready was low");
    end

    reset_state: assert property (@(posedge clk) rst |=> !out_valid && !redirect.valid)
    else begin
        fail_count++;
        $error("out_valid or redirect high in the cycle after reset");
    end

endmodule

//--- fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker
    import fetch_pkg::*;
#(
    parameter int PHASE_LEN   = 300,
    parameter int IMAGE_WORDS = 256
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  out_valid,
    input  addr_t out_pc,
    input  inst_t out_inst,
    input  logic  out_ready,
    input  inst_t image [IMAGE_WORDS],
    output int    retired,
    output int    failed,
    output logic  done
);

    string names [5] = '{"reset", "free flow", "instruction words", "back-pressure",
                         "memory stalls"};
    int    errs [5] = '{default: 0};
    int    passed;
    addr_t model_pc;

    // architectural next address of a word
    function automatic addr_t successor(addr_t pc, inst_t w);
        if (w[6:0] == JUMP_OPCODE) begin
            return {w[31:12], 12'h000};
        end
        return pc + 32'd4;
    endfunction

    task automatic finish_test(int t);
        if (errs[t] == 0) begin
            passed++;
            $display("test %0d %s: ok", t + 1, names[t]);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", t + 1, names[t], errs[t]);
        end
    endtask

    task automatic check_retired();
        inst_t want;
        inst_t word_at_pc;
        int    t;
        want       = image[(model_pc >> 2) % IMAGE_WORDS];
        word_at_pc = image[(out_pc >> 2) % IMAGE_WORDS];
        // test that owns the pc check in this phase
        t = (retired < PHASE_LEN) ? 1 : (retired < 2 * PHASE_LEN) ? 3 : 4;
        if (retired == 0 && out_pc !== RESET_PC) begin
            errs[0]++;
            $display("mismatch at %0t: first out_pc got %h expected %h",
                     $time, out_pc, RESET_PC);
        end
        if (out_pc !== model_pc) begin
            errs[t]++;
            $display("mismatch at %0t: out_pc got %h expected %h", $time, out_pc, model_pc);
        end
        if (out_inst !== word_at_pc) begin
            errs[2]++;
            $display("mismatch at %0t: out_inst got %h expected %h", $time, out_inst, word_at_pc);
        end
        model_pc = successor(model_pc, want);
        retired++;
        if (retired == 1) begin
            finish_test(0);
        end
        if (retired == PHASE_LEN) begin
            finish_test(1);
        end
        if (retired == 2 * PHASE_LEN) begin
            finish_test(3);
        end
        if (retired == 3 * PHASE_LEN) begin
            finish_test(4);
            finish_test(2);
            $display("summary: %0d passed, %0d failed", passed, failed);
            done = 1'b1;
        end
    endtask

    initial begin
        retired  = 0;
        failed   = 0;
        passed   = 0;
        done     = 1'b0;
        model_pc = RESET_PC;
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            if (out_valid !== 1'b0) begin
                errs[0]++;
                $display("mismatch at %0t: out_valid got %b expected 0 during reset",
                         $time, out_valid);
            end
        end else if (out_valid && out_ready && !done) begin
            check_retired();
        end
    end

endmodule

//--- tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int PHASE_LEN    = 300;
    localparam int IMAGE_WORDS  = 256;
    localparam int RESET_CYCLES = 16;
    // eight cycles per expected instruction plus slack
    localparam int CYCLE_LIMIT  = 8 * 3 * PHASE_LEN + 200;

    logic        clk = 1'b0;
    logic        rst;
    fetch_req_t  mem_req;
    logic        mem_ready;
    fetch_resp_t mem_resp;
    logic        out_valid;
    addr_t       out_pc;
    inst_t       out_inst;
    logic        out_ready;

    inst_t image [IMAGE_WORDS];
    int    retired;
    int    failed;
    logic  done;
    int    cycles;
    int    seed;
    int    phase;
    int    last_due;
    addr_t resp_addr [$];
    int    resp_due [$];

    always #4 clk = ~clk;

    fetch_top i_fetch_top (.*);

    fetch_checker #(.PHASE_LEN(PHASE_LEN), .IMAGE_WORDS(IMAGE_WORDS)) i_fetch_checker (.*);

    bind fetch_top fetch_assert i_fetch_assert (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_ready (out_ready),
        .redirect  (redirect)
    );

    function automatic logic roll_percent(int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    task automatic fill_image();
        inst_t w;
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            w = $random(seed);
            if (roll_percent(17)) begin
                // every jump page wraps back onto word 0 of the image
                w[6:0]   = JUMP_OPCODE;
                w[31:12] = 20'($unsigned($random(seed)) % 8);
            end else if (w[6:0] == JUMP_OPCODE) begin
                w[0] = ~w[0];
            end
            image[i] = w;
        end
    endtask

    task automatic drive_inputs();
        phase     = retired / PHASE_LEN;
        mem_ready = roll_percent(phase == 2 ? 50 : 80);
        out_ready = (phase == 0) ? 1'b1 : roll_percent(phase == 1 ? 30 : 80);
        mem_resp  = '0;
        if (resp_due.size() > 0 && resp_due[0] <= cycles) begin
            mem_resp.valid = 1'b1;
            mem_resp.addr  = resp_addr.pop_front();
            mem_resp.inst  = image[(mem_resp.addr >> 2) % IMAGE_WORDS];
            void'(resp_due.pop_front());
        end
    endtask

    // an accepted read is answered one to four cycles later and in order
    always @(negedge clk) begin
        int lat;
        if (!rst && mem_req.valid && mem_ready) begin
            lat      = (phase == 2) ? 4 : 1 + int'($unsigned($random(seed)) % 4);
            last_due = (cycles + lat > last_due) ? cycles + lat : last_due + 1;
            resp_addr.push_back(mem_req.addr);
            resp_due.push_back(last_due);
        end
    end

    initial begin
        seed      = 32'h1434_5a35;
        rst       = 1'b1;
        mem_ready = 1'b0;
        mem_resp  = '0;
        out_ready = 1'b0;
        cycles    = 0;
        phase     = 0;
        last_due  = 0;
        fill_image();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!done && cycles < CYCLE_LIMIT) begin
            drive_inputs();
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("run stalled: %0d of %0d instructions retired after %0d cycles",
                     retired, 3 * PHASE_LEN, cycles);
        end
        if (done && failed == 0 && i_fetch_top.i_fetch_assert.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
fetch_pkg.sv
predict_pkg.sv
branch_predictor.sv
inst_queue.sv
branch_resolve.sv
fetch_top.sv
fetch_assert.sv
fetch_checker.sv
tb_fetch.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FLAGS     ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
